//--- source/pdp8Pkg.sv
// PDP-8 shared definitions
// Word types, opcode and sequence encodings, sequencer timing flags
`default_nettype none

package pdp8Pkg;

  typedef logic [11:0] word12;
  typedef logic [11:0] address12;
  typedef logic [4:0]  stepCount;

  // Where the sequencer goes after fetch
  typedef enum logic [1:0] {
    seqDirect       = 2'd0,
    seqIndirect     = 2'd1,
    seqAutoIndex    = 2'd2,
    seqAutoIndexAlt = 2'd3   // Same path as seqAutoIndex
  } seqType;

  typedef enum logic [2:0] {
    opAnd, opTad, opIsz, opDca, opJms, opJmp, opIot, opOpr
  } opcode;

  typedef struct packed {
    logic ckFetch, ckAuto1, ckAuto2, ckInd;
    logic ckExec1, ckExec2, ckExec3, ckExec4, ckExec5, ckExec6;
    logic stbFetch, stbAuto1, stbAuto2, stbInd;
    logic stbExec1, stbExec2, stbExec3, stbExec4, stbExec5, stbExec6;
  } timingBus;

  typedef struct packed {
    opcode    op;
    logic     indirect;
    address12 address;   // Effective address, page already applied
    logic [8:0] micro;
  } decodedInst;

  localparam address12 resetPc = 12'o0200;
  localparam int memWords = 4096;

  // Sequencer step numbers
  localparam stepCount stepFetch  = 5'd0;
  localparam stepCount stepBranch = 5'd1;
  localparam stepCount stepAuto1  = 5'd2;
  localparam stepCount stepInd    = 5'd6;
  localparam stepCount stepExec1  = 5'd8;
  localparam stepCount stepIdle   = 5'd31;

  // Page-zero auto-index locations 010-017
  localparam logic [3:0] autoIndexBlock = 4'b0001;

endpackage

`default_nettype wire

//--- source/sequencer.sv
// PDP-8 step sequencer
// Run/single-instruction control and ck/stb timing window generation
`timescale 1ns/10ps
`default_nettype none

module sequencer (
  input  wire logic             clk,
  input  wire logic             reset,
  input  wire logic             startStop,
  input  wire logic             singleStep,
  input  wire logic             done,
  input  wire logic             haltRequest,
  input  wire pdp8Pkg::seqType  seqSelect,
  output pdp8Pkg::timingBus     timing,
  output logic                  running
);
  import pdp8Pkg::*;

  stepCount   stepCnt;
  stepCount   stepNext;
  logic       singleInst;
  logic       stopPending;   // Stop requested, taken at end of instruction
  logic       lastStartStop;
  logic       lastSingleStep;
  logic       startEdge;
  logic       stepEdge;
  logic       runNext;
  logic       singleNext;
  logic [3:0] window;
  logic [9:0] ckHit;
  logic [9:0] stbHit;

  assign startEdge = startStop & ~lastStartStop;
  assign stepEdge  = singleStep & ~lastSingleStep;

  always_comb begin
    if (haltRequest || (done && stopPending)) begin
      runNext = 1'b0;
    end else if (startEdge && !running) begin
      runNext = 1'b1;
    end else begin
      runNext = running;
    end
  end

  assign singleNext = (stepEdge & ~running) | (singleInst & ~done);

  // Normal advance, branching after fetch
  always_comb begin
    stepNext = stepCnt + 5'd1;
    if (stepCnt == stepBranch) begin
      case (seqSelect)
        seqDirect:   stepNext = stepExec1;
        seqIndirect: stepNext = stepInd;
        default:     stepNext = stepAuto1;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stepCnt        <= stepIdle;
      running        <= 1'b0;
      singleInst     <= 1'b0;
      stopPending    <= 1'b0;
      lastStartStop  <= 1'b0;
      lastSingleStep <= 1'b0;
    end else begin
      lastStartStop  <= startStop;
      lastSingleStep <= singleStep;
      running        <= runNext;
      singleInst     <= singleNext;
      stopPending    <= (running & startEdge) | (stopPending & ~done);
      if (done) begin
        stepCnt <= (runNext | singleNext) ? stepFetch : stepIdle; // Park at 31 when stopping
      end else if (running || singleInst) begin
        stepCnt <= stepNext;
      end
    end
  end

  assign window = stepCnt[4:1];
  assign ckHit  = reset ? 10'd0 : (10'd1 << window);  // Steps 20 and up hit nothing
  assign stbHit = ckHit & {10{stepCnt[0]}};

  assign timing.ckFetch  = ckHit[0];
  assign timing.ckAuto1  = ckHit[1];
  assign timing.ckAuto2  = ckHit[2];
  assign timing.ckInd    = ckHit[3];
  assign timing.ckExec1  = ckHit[4];
  assign timing.ckExec2  = ckHit[5];
  assign timing.ckExec3  = ckHit[6];
  assign timing.ckExec4  = ckHit[7];
  assign timing.ckExec5  = ckHit[8];
  assign timing.ckExec6  = ckHit[9];
  assign timing.stbFetch = stbHit[0];
  assign timing.stbAuto1 = stbHit[1];
  assign timing.stbAuto2 = stbHit[2];
  assign timing.stbInd   = stbHit[3];
  assign timing.stbExec1 = stbHit[4];
  assign timing.stbExec2 = stbHit[5];
  assign timing.stbExec3 = stbHit[6];
  assign timing.stbExec4 = stbHit[7];
  assign timing.stbExec5 = stbHit[8];
  assign timing.stbExec6 = stbHit[9];

endmodule

`default_nettype wire

//--- source/instructionDecoder.sv
// PDP-8 instruction decoder
// Picks the post-fetch sequence and holds the decoded instruction
`timescale 1ns/10ps
`default_nettype none

module instructionDecoder (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire pdp8Pkg::timingBus  timing,
  input  wire pdp8Pkg::word12     readData,
  input  wire pdp8Pkg::address12  pc,
  output pdp8Pkg::seqType         seqSelect,
  output pdp8Pkg::decodedInst     inst
);
  import pdp8Pkg::*;

  logic isMemRef;
  logic pageBit;

  assign isMemRef = (readData[11:9] < 3'd6);  // IOT and OPR take no operand
  assign pageBit  = readData[7];

  always_comb begin
    if (!isMemRef || !readData[8]) begin
      seqSelect = seqDirect;
    end else if (!pageBit && readData[6:3] == autoIndexBlock) begin
      seqSelect = seqAutoIndex;
    end else begin
      seqSelect = seqIndirect;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      inst <= '0;
    end else if (timing.stbFetch) begin
      inst.op       <= opcode'(readData[11:9]);
      inst.indirect <= readData[8];
      inst.address  <= pageBit ? {pc[11:7], readData[6:0]} : {5'd0, readData[6:0]}; // pc not yet bumped
      inst.micro    <= readData[8:0];
    end
  end

endmodule

`default_nettype wire

//--- source/coreMemory.sv
// PDP-8 core memory, 4K x 12
// Combinational read, processor write and an external load port
`timescale 1ns/10ps
`default_nettype none

module coreMemory (
  input  wire logic               clk,
  input  wire pdp8Pkg::address12  address,
  input  wire pdp8Pkg::word12     writeData,
  input  wire logic               write,
  input  wire logic               loadEnable,
  input  wire pdp8Pkg::address12  loadAddress,
  input  wire pdp8Pkg::word12     loadData,
  output pdp8Pkg::word12          readData
);
  import pdp8Pkg::*;

  word12 mem [memWords];

  always_ff @(posedge clk) begin
    if (loadEnable) begin
      mem[loadAddress] <= loadData;   // Loader wins
    end else if (write) begin
      mem[address] <= writeData;
    end
  end

  assign readData = mem[address];

endmodule

`default_nettype wire

//--- source/execUnit.sv
// PDP-8 execute unit
// Holds PC, AC, link and MB, drives memory and runs each opcode
`timescale 1ns/10ps
`default_nettype none

module execUnit (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire pdp8Pkg::timingBus    timing,
  input  wire pdp8Pkg::decodedInst  inst,
  input  wire pdp8Pkg::word12       readData,
  output pdp8Pkg::address12         memAddress,
  output pdp8Pkg::word12            memWriteData,
  output logic                      memWrite,
  output logic                      done,
  output logic                      haltRequest,
  output pdp8Pkg::address12         pc,
  output pdp8Pkg::word12            ac,
  output logic                      link
);
  import pdp8Pkg::*;

  word12     mb;
  address12  operandAddr;   // Pointer contents after indirection
  address12  target;
  logic      isMemRef;
  logic      isOpr;
  logic      lastExec1;
  logic      lastExec2;
  logic      lastExec3;
  logic      writesOperand;
  logic [12:0] tadSum;

  assign isMemRef = (inst.op < opIot);
  assign isOpr    = (inst.op == opOpr);
  assign target   = (isMemRef && inst.indirect) ? operandAddr : inst.address;
  assign tadSum   = {1'b0, ac} + {1'b0, mb};

  // Which exec window ends the instruction
  assign lastExec1 = (inst.op == opJmp) || (inst.op == opIot) || isOpr;
  assign lastExec2 = (inst.op == opAnd) || (inst.op == opTad) || (inst.op == opDca);
  assign lastExec3 = (inst.op == opIsz) || (inst.op == opJms);
  assign writesOperand = (inst.op == opDca) || (inst.op == opIsz) || (inst.op == opJms);

  assign done = (timing.stbExec1 & lastExec1) | (timing.stbExec2 & lastExec2) |
                (timing.stbExec3 & lastExec3);
  // Group 2 OPR with HLT
  assign haltRequest = timing.stbExec1 & isOpr & inst.micro[8] & ~inst.micro[0] &
                       inst.micro[1];

  always_comb begin
    if (timing.ckFetch) begin
      memAddress = pc;
    end else if (timing.ckAuto1 || timing.ckAuto2 || timing.ckInd) begin
      memAddress = inst.address;   // Pointer location
    end else begin
      memAddress = target;
    end
  end

  assign memWriteData = timing.ckAuto1 ? readData + 12'd1 : mb;
  assign memWrite     = timing.stbAuto1 | (timing.stbExec2 & writesOperand);

  always_ff @(posedge clk) begin
    if (timing.stbInd) operandAddr <= readData;
    if (timing.stbExec1) begin
      case (inst.op)
        opAnd, opTad: mb <= readData;
        opIsz:        mb <= readData + 12'd1;
        opDca:        mb <= ac;
        opJms:        mb <= pc;  // Return address, already past the JMS
        default:      mb <= mb;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc   <= resetPc;
      ac   <= '0;
      link <= 1'b0;
    end else begin
      if (timing.stbFetch) pc <= pc + 12'd1;
      if (timing.stbExec1) begin
        if (inst.op == opJmp) pc <= target;
        if (isOpr && !inst.micro[8]) begin
          if (inst.micro[7]) ac <= '0;    // CLA
          if (inst.micro[6]) link <= 1'b0; // CLL
        end
      end
      if (timing.stbExec2) begin
        case (inst.op)
          opAnd: ac <= ac & mb;
          opTad: begin
            ac   <= tadSum[11:0];
            link <= link ^ tadSum[12];
          end
          opDca:   ac <= '0;
          default: ac <= ac;
        endcase
      end
      if (timing.stbExec3) begin
        if (inst.op == opIsz && mb == 12'd0) pc <= pc + 12'd1; // Skip on zero
        if (inst.op == opJms) pc <= target + 12'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- source/pdp8Core.sv
// PDP-8 core top level
// Sequencer, decoder, core memory and execute unit wired together
`timescale 1ns/10ps
`default_nettype none

module pdp8Core (
  input  wire logic               clk,
  input  wire logic               reset,
  input  wire logic               startStop,
  input  wire logic               singleStep,
  input  wire logic               loadEnable,
  input  wire pdp8Pkg::address12  loadAddress,
  input  wire pdp8Pkg::word12     loadData,
  output logic                    running,
  output pdp8Pkg::address12       pc,
  output pdp8Pkg::word12          ac,
  output logic                    link
);
  import pdp8Pkg::*;

  timingBus   timing;
  seqType     seqSelect;
  decodedInst inst;
  address12   memAddress;
  word12      memWriteData;
  word12      readData;
  logic       memWrite;
  logic       done;
  logic       haltRequest;

  sequencer i_sequencer (
    .clk, .reset, .startStop, .singleStep, .done, .haltRequest,
    .seqSelect, .timing, .running
  );

  instructionDecoder i_instructionDecoder (
    .clk, .reset, .timing, .readData, .pc, .seqSelect, .inst
  );

  coreMemory i_coreMemory (
    .clk, .address(memAddress), .writeData(memWriteData), .write(memWrite),
    .loadEnable, .loadAddress, .loadData, .readData
  );

  execUnit i_execUnit (
    .clk, .reset, .timing, .inst, .readData, .memAddress, .memWriteData,
    .memWrite, .done, .haltRequest, .pc, .ac, .link
  );

endmodule

`default_nettype wire

//--- test/pdp8Core_checker.sv
// Sequencer timing checks
// Window, strobe and idle rules on the ck/stb flags
`timescale 1ns/10ps
`default_nettype none

module pdp8CoreChecker (
  input wire logic               clk,
  input wire logic               reset,
  input wire logic               running,
  input wire logic               singleInst,
  input wire pdp8Pkg::timingBus  timing
);
  logic [9:0] ckFlags;
  logic [9:0] stbFlags;

  assign ckFlags  = timing[19:10];  // ckFetch down to ckExec6
  assign stbFlags = timing[9:0];    // Same order as the ck flags

  // A strobe never lands in two steps in a row
  oneWindow: assert property (@(posedge clk) disable iff (reset)
    $onehot0(ckFlags) && (stbFlags == 10'd0 || $past(stbFlags) == 10'd0))
    else $error("Window overlap or repeated strobe: ck %b stb %b", ckFlags, stbFlags);

  // Strobe in the second step of a window already open
  strobeInWindow: assert property (@(posedge clk) disable iff (reset)
    (stbFlags != 10'd0) |-> (stbFlags == ckFlags && $past(ckFlags) == ckFlags))
    else $error("Strobe outside its window: ck %b stb %b", ckFlags, stbFlags);

  idleWhenStopped: assert property (@(posedge clk) disable iff (reset)
    (!running && !singleInst) |-> (ckFlags == 10'd0 && stbFlags == 10'd0))
    else $error("Timing active while stopped: ck %b stb %b", ckFlags, stbFlags);

  quietInReset: assert property (@(posedge clk)
    reset |=> (ckFlags == 10'd0 && stbFlags == 10'd0))
    else $error("Timing active after reset: ck %b stb %b", ckFlags, stbFlags);

endmodule

bind sequencer pdp8CoreChecker i_checker (
  .clk(clk), .reset(reset), .running(running), .singleInst(singleInst), .timing(timing)
);

`default_nettype wire

//--- test/pdp8CoreTb.sv
// PDP-8 core testbench
// Directed programs go in through the load port, results come from architectural rules
`timescale 1ns/10ps
`default_nettype none

module pdp8CoreTb;
  import pdp8Pkg::*;

  // About 55 instructions run over all tests at 14 clocks worst case, plus load and reset time
  localparam int instrTotal = 60;
  localparam int cycleLimit = 14 * instrTotal + 400;
  localparam int arrayLen   = 5;

  logic     clk;
  logic     reset;
  logic     startStop;
  logic     singleStep;
  logic     loadEnable;
  address12 loadAddress;
  word12    loadData;
  logic     running;
  address12 pc;
  word12    ac;
  logic     link;

  int          errorCount = 0;
  int          checkCount = 0;
  logic [31:0] lcgState   = 32'hd4bd;

  pdp8Core i_pdp8Core (
    .clk, .reset, .startStop, .singleStep, .loadEnable, .loadAddress, .loadData,
    .running, .pc, .ac, .link
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin : watchdog
    int cycleCount;
    cycleCount = 0;
    while (cycleCount < cycleLimit) begin
      @(posedge clk);
      cycleCount++;
    end
    $display("Timeout: simulation ran past %0d clock cycles", cycleLimit);
    $display(">>> FAIL");
    $finish;
  end

  function automatic word12 randomWord();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[27:16];  // Upper bits, the low ones repeat quickly
  endfunction

  task automatic checkWord(string name, word12 got, word12 expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("[ERROR] %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic checkAddress(string name, address12 got, address12 expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("[ERROR] %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic checkFlag(string name, logic got, logic expected);
    checkCount++;
    if (got !== expected) begin
      errorCount++;
      $display("[ERROR] %s: got %h, expected %h", name, got, expected);
    end
  endtask

  task automatic applyReset();
    @(posedge clk);
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic writeWord(address12 addr, word12 data);
    @(posedge clk);
    loadEnable  <= 1'b1;
    loadAddress <= addr;
    loadData    <= data;
  endtask

  task automatic endLoad();
    @(posedge clk);
    loadEnable <= 1'b0;
  endtask

  task automatic pulseStartStop();
    @(posedge clk);
    startStop <= 1'b1;
    @(posedge clk);
    startStop <= 1'b0;
  endtask

  task automatic waitForStop(string testName, int bound);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (running && cycles < bound) begin
      @(negedge clk);
      cycles++;
    end
    if (running) begin
      errorCount++;
      $display("%s: processor still running after %0d cycles", testName, bound);
    end
  endtask

  task automatic resetValues();
    applyReset();
    @(negedge clk);
    checkFlag("running", running, 1'b0);
    checkAddress("pc", pc, 12'o0200);
    checkWord("ac", ac, 12'o0000);
    checkFlag("link", link, 1'b0);
  endtask

  task automatic directArithmetic();
    word12       a;
    word12       b;
    word12       mask;
    logic [12:0] sum;
    for (int pass = 0; pass < 3; pass++) begin
      a    = randomWord();
      b    = randomWord();
      mask = randomWord();
      if (pass == 0) begin
        a[11] = 1'b1;  // Both high bits set, so the add carries
        b[11] = 1'b1;
      end
      applyReset();
      writeWord(12'o0200, 12'o7300);  // CLA CLL
      writeWord(12'o0201, 12'o1250);  // TAD A
      writeWord(12'o0202, 12'o1251);  // TAD B
      writeWord(12'o0203, 12'o0252);  // AND MASK
      writeWord(12'o0204, 12'o3253);  // DCA T
      writeWord(12'o0205, 12'o1253);  // TAD T
      writeWord(12'o0206, 12'o7402);  // HLT
      writeWord(12'o0250, a);
      writeWord(12'o0251, b);
      writeWord(12'o0252, mask);
      endLoad();
      pulseStartStop();
      waitForStop("Direct arithmetic", 7 * 14 + 4);
      sum = {1'b0, a} + {1'b0, b};
      checkWord("ac", ac, sum[11:0] & mask);
      checkFlag("link", link, sum[12]);
      checkAddress("pc", pc, 12'o0207);
    end
  endtask

  task automatic autoIndexLoop();
    word12 elem;
    word12 sum;
    sum = '0;
    applyReset();
    // Auto-index increments before use, so the pointer starts one below the array
    writeWord(12'o0010, 12'o0277);
    writeWord(12'o0200, 12'o7300);  // CLA CLL
    writeWord(12'o0201, 12'o1410);  // TAD I 010
    writeWord(12'o0202, 12'o2260);  // ISZ CNT
    writeWord(12'o0203, 12'o5201);  // JMP 0201
    writeWord(12'o0204, 12'o7402);  // HLT
    writeWord(12'o0260, 12'd0 - word12'(arrayLen));
    for (int i = 0; i < arrayLen; i++) begin
      elem = randomWord();
      sum  = sum + elem;            // Wraps modulo 4096
      writeWord(12'o0300 + address12'(i), elem);
    end
    endLoad();
    pulseStartStop();
    waitForStop("Auto-index loop", (3 * arrayLen + 2) * 14 + 4);
    checkWord("ac", ac, sum);
    checkAddress("pc", pc, 12'o0205);
  endtask

  task automatic subroutineCall();
    word12       x;
    word12       k;
    address12    jmsAddr;
    logic [12:0] sum;
    x       = randomWord();
    k       = randomWord();
    jmsAddr = 12'o0202;
    applyReset();
    writeWord(12'o0200, 12'o7300);  // CLA CLL
    writeWord(12'o0201, 12'o1250);  // TAD X
    writeWord(jmsAddr, 12'o4260);   // JMS 0260
    writeWord(12'o0203, 12'o7402);  // HLT, the return point
    writeWord(12'o0250, x);
    writeWord(12'o0260, 12'o0000);  // Return slot
    writeWord(12'o0261, 12'o1270);  // TAD K
    writeWord(12'o0262, 12'o5660);  // JMP I 0260
    writeWord(12'o0270, k);
    endLoad();
    pulseStartStop();
    waitForStop("Subroutine", 6 * 14 + 4);
    sum = {1'b0, x} + {1'b0, k};
    checkWord("ac", ac, sum[11:0]);
    checkFlag("link", link, sum[12]);
    checkAddress("pc", pc, jmsAddr + 12'd2);  // HLT at jmsAddr+1 leaves pc one past it
  endtask

  task automatic singleInstruction();
    word12 x;
    int    cycles;
    x      = randomWord();
    cycles = 0;
    applyReset();
    writeWord(12'o0200, 12'o1250);  // TAD X
    writeWord(12'o0201, 12'o7402);  // HLT, must not run
    writeWord(12'o0250, x);
    endLoad();
    @(posedge clk);
    singleStep <= 1'b1;
    @(posedge clk);
    singleStep <= 1'b0;
    @(negedge clk);
    while (!i_pdp8Core.done && cycles < 16) begin
      @(negedge clk);
      cycles++;
    end
    if (!i_pdp8Core.done) begin
      errorCount++;
      $display("Single instruction: no instruction completed within 16 cycles");
    end
    repeat (20) @(negedge clk);     // Room for a second instruction that must not come
    checkFlag("running", running, 1'b0);
    checkAddress("pc", pc, 12'o0201);
    checkWord("ac", ac, x);
  endtask

  task automatic startStopToggle();
    applyReset();
    writeWord(12'o0200, 12'o5200);  // JMP to itself
    endLoad();
    pulseStartStop();
    repeat (20) @(negedge clk);
    checkFlag("running", running, 1'b1);
    pulseStartStop();
    waitForStop("Start/stop toggle", 14 + 4);
    checkFlag("running", running, 1'b0);
    checkAddress("pc", pc, 12'o0200);
  endtask

  initial begin
    reset       = 1'b1;
    startStop   = 1'b0;
    singleStep  = 1'b0;
    loadEnable  = 1'b0;
    loadAddress = '0;
    loadData    = '0;
    resetValues();
    directArithmetic();
    autoIndexLoop();
    subroutineCall();
    singleInstruction();
    startStopToggle();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
source/pdp8Pkg.sv
source/sequencer.sv
source/instructionDecoder.sv
source/coreMemory.sv
source/execUnit.sv
source/pdp8Core.sv
test/pdp8Core_checker.sv
test/pdp8CoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the PDP-8 core testbench with Verilator

cd "$(dirname "$0")" || exit 1
logFile=sim.log

verilator --binary --assert --timescale 1ns/10ps --top-module pdp8CoreTb \
  -f project.f --Mdir build -o simPdp8
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./build/simPdp8 > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qF ">>> FAIL" "$logFile"; then
  exit 1
fi
exit 0
